//--- bfPkg.sv
package bfPkg;

    typedef logic [7:0] nodeIdT;
    typedef logic signed [7:0] weightT;
    typedef logic signed [7:0] distT;     // Wraps on overflow, no saturation
    typedef logic [12:0] memAddrT;
    typedef logic [127:0] lineT;
    typedef logic [15:0] outWordT;

    typedef enum logic [3:0] {
        CtInit,
        CtClear,
        CtSeed,
        CtRead,
        CtWait1,
        CtWait2,
        CtCheck,
        CtEdges,
        CtNext,
        CtRoundEnd,
        CtWalk,
        CtWalkWait,
        CtDone
    } ctrlStateT;

    typedef enum logic [2:0] {
        StIdle,
        StClear,
        StWait1,
        StWait2,
        StRelax,
        StWalk,
        StWalkEnd
    } storeStateT;

    // Working memory entry
    localparam int InfBit = 127;
    localparam int DistMsb = 126;
    localparam int DistLsb = 119;
    localparam int PredMsb = 118;
    localparam int PredLsb = 111;
    localparam int SrcMarkBit = 108;

    // Graph memory adjacency lines
    localparam logic [3:0] FirstLinePairs = 4'd7;
    localparam logic [3:0] LinePairs = 4'd8;
    localparam int LinkCountMsb = 119;
    localparam int LinkCountLsb = 112;

    localparam outWordT PathEnd = 16'hFFFF;

endpackage

//--- bfController.sv
module bfController
    import bfPkg::*;
(
    input  logic    clock,
    input  logic    reset,
    output memAddrT inAddr,
    input  nodeIdT  inData,
    output memAddrT workAddrA,
    input  lineT    workDataA,
    output logic    fetchStart,
    output nodeIdT  fetchNode,
    input  logic    edgesDone,
    output logic    clearStart,
    output logic    seedStart,
    output nodeIdT  seedNode,
    input  logic    clearDone,
    input  logic    seedDone,
    input  logic    updated,
    output nodeIdT  nodeCount,
    output distT    distU,
    output nodeIdT  nodeU,
    output logic    walkStart,
    output nodeIdT  walkNode,
    input  logic    writeDone,
    output logic    negCycle,
    output logic    done
);

    ctrlStateT state;
    nodeIdT inDataReg;
    lineT workDataRegA;
    nodeIdT sweepNode;
    nodeIdT round;
    logic anyUpdate;    // Some relaxation wrote during this round

    always_ff @(posedge clock)
    begin
        inDataReg <= inData;
        workDataRegA <= workDataA;
    end

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            state <= CtInit;
            inAddr <= '0;    // Word 0 is already in inDataReg when reset falls
            workAddrA <= '0;
            fetchStart <= 1'b0;
            clearStart <= 1'b0;
            seedStart <= 1'b0;
            walkStart <= 1'b0;
            negCycle <= 1'b0;
            done <= 1'b0;
            anyUpdate <= 1'b0;
            sweepNode <= '0;
            round <= '0;
        end
        else
        begin
            fetchStart <= 1'b0;
            clearStart <= 1'b0;
            seedStart <= 1'b0;
            walkStart <= 1'b0;
            if (updated)
                anyUpdate <= 1'b1;
            case (state)
                CtInit:
                begin
                    nodeCount <= inDataReg;
                    clearStart <= 1'b1;
                    inAddr <= 13'd1;
                    state <= CtClear;
                end
                CtClear:
                    if (clearDone)
                    begin
                        seedNode <= inDataReg;
                        seedStart <= 1'b1;
                        inAddr <= 13'd2;    // Destination stays here until the walk
                        state <= CtSeed;
                    end
                CtSeed:
                    if (seedDone)
                    begin
                        round <= 8'd1;
                        sweepNode <= 8'd1;
                        anyUpdate <= 1'b0;
                        state <= CtRead;
                    end
                CtRead:
                begin
                    workAddrA <= {5'b0, sweepNode};
                    state <= CtWait1;
                end
                CtWait1:
                    state <= CtWait2;
                CtWait2:
                    state <= CtCheck;
                CtCheck:
                    if (workDataRegA[InfBit])
                        state <= CtNext;    // Not reached yet, nothing to relax
                    else
                    begin
                        distU <= workDataRegA[DistMsb:DistLsb];
                        nodeU <= sweepNode;
                        fetchNode <= sweepNode;
                        fetchStart <= 1'b1;
                        state <= CtEdges;
                    end
                CtEdges:
                    if (edgesDone)
                        state <= CtNext;
                CtNext:
                    if (sweepNode == nodeCount)
                        state <= CtRoundEnd;
                    else
                    begin
                        sweepNode <= sweepNode + 8'd1;
                        state <= CtRead;
                    end
                CtRoundEnd:
                    if (!anyUpdate)
                        state <= CtWalk;
                    else if (round == nodeCount)
                    begin
                        // Round N is the extra check round
                        negCycle <= 1'b1;
                        done <= 1'b1;
                        state <= CtDone;
                    end
                    else
                    begin
                        round <= round + 8'd1;
                        sweepNode <= 8'd1;
                        anyUpdate <= 1'b0;
                        state <= CtRead;
                    end
                CtWalk:
                begin
                    walkNode <= inDataReg;
                    walkStart <= 1'b1;
                    state <= CtWalkWait;
                end
                CtWalkWait:
                    if (writeDone)
                    begin
                        done <= 1'b1;
                        state <= CtDone;
                    end
                default:
                    state <= CtDone;
            endcase
        end
    end

    sweepInRange: assert property (@(posedge clock) disable iff (reset)
        state == CtRead |-> sweepNode >= 8'd1 && sweepNode <= nodeCount);

endmodule

//--- bfEdgeFetch.sv
module bfEdgeFetch
    import bfPkg::*;
(
    input  logic    clock,
    input  logic    reset,
    output memAddrT graphAddr,
    input  lineT    graphData,
    input  logic    fetchStart,
    input  nodeIdT  fetchNode,
    output logic    edgeValid,
    output nodeIdT  edgeTarget,
    output weightT  edgeWeight,
    input  logic    edgeAck,
    output logic    edgesDone
);

    typedef enum logic [2:0] {
        FeIdle,
        FeWait1,
        FeWait2,
        FeIndex,
        FeLoad,
        FeEmit,
        FeDone
    } fetchStateT;

    fetchStateT state;
    lineT graphDataReg;
    lineT pairLine;     // Current pair sits in the top 16 bits
    nodeIdT linksLeft;
    logic [3:0] pairsLeft;
    logic indexPhase;
    logic firstLine;

    always_ff @(posedge clock)
        graphDataReg <= graphData;

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            state <= FeIdle;
            graphAddr <= '0;
            indexPhase <= 1'b0;
            firstLine <= 1'b0;
            linksLeft <= '0;
            pairsLeft <= '0;
        end
        else
            case (state)
                FeIdle:
                    if (fetchStart)
                    begin
                        graphAddr <= {5'b0, fetchNode};
                        indexPhase <= 1'b1;
                        state <= FeWait1;
                    end
                FeWait1:
                    state <= FeWait2;
                FeWait2:
                    state <= indexPhase ? FeIndex : FeLoad;
                FeIndex:
                begin
                    graphAddr <= graphDataReg[12:0];
                    indexPhase <= 1'b0;
                    firstLine <= 1'b1;
                    state <= FeWait1;
                end
                FeLoad:
                    if (firstLine)
                    begin
                        linksLeft <= graphDataReg[LinkCountMsb:LinkCountLsb];
                        pairLine <= graphDataReg << 16;    // Drop the link count slot
                        pairsLeft <= FirstLinePairs;
                        if (graphDataReg[LinkCountMsb:LinkCountLsb] == 8'd0)
                            state <= FeDone;
                        else
                            state <= FeEmit;
                    end
                    else
                    begin
                        pairLine <= graphDataReg;
                        pairsLeft <= LinePairs;
                        state <= FeEmit;
                    end
                FeEmit:
                    if (edgeAck)
                    begin
                        pairLine <= pairLine << 16;
                        linksLeft <= linksLeft - 8'd1;
                        pairsLeft <= pairsLeft - 4'd1;
                        if (linksLeft == 8'd1)
                            state <= FeDone;
                        else if (pairsLeft == 4'd1)
                        begin
                            graphAddr <= graphAddr + 13'd1;    // Continuation line
                            firstLine <= 1'b0;
                            state <= FeWait1;
                        end
                    end
                default:
                    state <= FeIdle;
            endcase
    end

    assign edgeValid = (state == FeEmit);
    assign edgesDone = (state == FeDone);
    assign edgeTarget = pairLine[127:120];
    assign edgeWeight = pairLine[119:112];

    ackWithEdge: assert property (@(posedge clock) disable iff (reset)
        edgeAck |-> edgeValid);

endmodule

//--- bfDistanceStore.sv
module bfDistanceStore
    import bfPkg::*;
(
    input  logic    clock,
    input  logic    reset,
    output memAddrT workAddrB,
    input  lineT    workDataB,
    output memAddrT workWrAddr,
    output lineT    workWrData,
    output logic    workWe,
    input  logic    clearStart,
    input  logic    seedStart,
    input  nodeIdT  seedNode,
    output logic    clearDone,
    output logic    seedDone,
    input  nodeIdT  nodeCount,
    input  logic    edgeValid,
    input  nodeIdT  edgeTarget,
    input  weightT  edgeWeight,
    input  distT    distU,
    input  nodeIdT  nodeU,
    output logic    edgeAck,
    output logic    updated,
    input  logic    walkStart,
    input  nodeIdT  walkNode,
    output logic    pathValid,
    output nodeIdT  pathNode,
    output distT    pathDist,
    output logic    pathEnd
);

    storeStateT state;
    lineT workDataRegB;
    logic walking;
    distT newDist;

    assign newDist = distU + edgeWeight;

    always_ff @(posedge clock)
        workDataRegB <= workDataB;

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            state <= StIdle;
            workAddrB <= '0;
            workWe <= 1'b0;
            clearDone <= 1'b0;
            seedDone <= 1'b0;
            edgeAck <= 1'b0;
            updated <= 1'b0;
            pathValid <= 1'b0;
            pathEnd <= 1'b0;
            walking <= 1'b0;
        end
        else
        begin
            workWe <= 1'b0;
            clearDone <= 1'b0;
            seedDone <= 1'b0;
            edgeAck <= 1'b0;
            updated <= 1'b0;
            pathValid <= 1'b0;
            pathEnd <= 1'b0;
            case (state)
                StIdle:
                    if (clearStart)
                    begin
                        workWrAddr <= 13'd1;
                        workWrData <= '0;
                        workWrData[InfBit] <= 1'b1;
                        workWe <= 1'b1;
                        state <= StClear;
                    end
                    else if (seedStart)
                    begin
                        workWrAddr <= {5'b0, seedNode};
                        workWrData <= '0;
                        workWrData[PredMsb:PredLsb] <= seedNode;
                        workWrData[SrcMarkBit] <= 1'b1;
                        workWe <= 1'b1;
                        seedDone <= 1'b1;
                    end
                    else if (walkStart)
                    begin
                        workAddrB <= {5'b0, walkNode};
                        walking <= 1'b1;
                        state <= StWait1;
                    end
                    else if (edgeValid && !edgeAck)    // Skip the edge just acked
                    begin
                        workAddrB <= {5'b0, edgeTarget};
                        walking <= 1'b0;
                        state <= StWait1;
                    end
                StClear:
                    if (workWrAddr == {5'b0, nodeCount})
                    begin
                        clearDone <= 1'b1;
                        state <= StIdle;
                    end
                    else
                    begin
                        workWrAddr <= workWrAddr + 13'd1;
                        workWe <= 1'b1;
                    end
                StWait1:
                    state <= StWait2;
                StWait2:
                    state <= walking ? StWalk : StRelax;
                StRelax:
                begin
                    if (workDataRegB[InfBit] || $signed(workDataRegB[DistMsb:DistLsb]) > newDist)
                    begin
                        workWrAddr <= {5'b0, edgeTarget};
                        workWrData <= workDataRegB;    // Source mark carries over
                        workWrData[InfBit] <= 1'b0;
                        workWrData[DistMsb:DistLsb] <= newDist;
                        workWrData[PredMsb:PredLsb] <= nodeU;
                        workWe <= 1'b1;
                        updated <= 1'b1;
                    end
                    edgeAck <= 1'b1;
                    state <= StIdle;
                end
                StWalk:
                    if (workDataRegB[InfBit])
                    begin
                        pathEnd <= 1'b1;    // Destination never reached
                        state <= StIdle;
                    end
                    else
                    begin
                        pathValid <= 1'b1;
                        pathNode <= workAddrB[7:0];
                        pathDist <= workDataRegB[DistMsb:DistLsb];
                        workAddrB <= {5'b0, workDataRegB[PredMsb:PredLsb]};
                        state <= workDataRegB[SrcMarkBit] ? StWalkEnd : StWait1;
                    end
                StWalkEnd:
                begin
                    pathEnd <= 1'b1;
                    state <= StIdle;
                end
                default:
                    state <= StIdle;
            endcase
        end
    end

    noWriteInWalk: assert property (@(posedge clock) disable iff (reset)
        walking |-> !workWe);

endmodule

//--- bfPathWriter.sv
module bfPathWriter
    import bfPkg::*;
#(
    parameter memAddrT OutBase = 13'h0000
)
(
    input  logic    clock,
    input  logic    reset,
    input  logic    pathValid,
    input  nodeIdT  pathNode,
    input  distT    pathDist,
    input  logic    pathEnd,
    output memAddrT outWrAddr,
    output outWordT outWrData,
    output logic    outWe,
    output logic    writeDone
);

    logic firstPulse;   // Next pathValid is the destination
    logic nodeHeld;
    logic endHeld;
    nodeIdT heldNode;

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            outWrAddr <= OutBase;
            outWe <= 1'b0;
            writeDone <= 1'b0;
            firstPulse <= 1'b1;
            nodeHeld <= 1'b0;
            endHeld <= 1'b0;
        end
        else
        begin
            outWe <= 1'b0;
            writeDone <= 1'b0;
            if (outWe)
                outWrAddr <= outWrAddr + 13'd1;
            if (pathValid)
            begin
                outWe <= 1'b1;
                if (firstPulse)
                begin
                    // Distance goes first, destination node one cycle later
                    outWrData <= {{8{pathDist[7]}}, pathDist};
                    heldNode <= pathNode;
                    nodeHeld <= 1'b1;
                    firstPulse <= 1'b0;
                end
                else
                    outWrData <= {8'h00, pathNode};
            end
            else if (nodeHeld)
            begin
                outWrData <= {8'h00, heldNode};
                outWe <= 1'b1;
                nodeHeld <= 1'b0;
                endHeld <= pathEnd;    // Source equals destination
            end
            else if (pathEnd || endHeld)
            begin
                outWrData <= PathEnd;
                outWe <= 1'b1;
                writeDone <= 1'b1;
                endHeld <= 1'b0;
                firstPulse <= 1'b1;
            end
        end
    end

endmodule

//--- bellmanFordTop.sv
module bellmanFordTop
    import bfPkg::*;
#(
    parameter memAddrT OutBase = 13'h1000
)
(
    input  logic    clock,
    input  logic    reset,
    output memAddrT inAddr,
    input  nodeIdT  inData,
    output memAddrT graphAddr,
    input  lineT    graphData,
    output memAddrT workAddrA,
    output memAddrT workAddrB,
    input  lineT    workDataA,
    input  lineT    workDataB,
    output memAddrT workWrAddr,
    output lineT    workWrData,
    output logic    workWe,
    output memAddrT outWrAddr,
    output outWordT outWrData,
    output logic    outWe,
    output logic    negCycle,
    output logic    done
);

    logic fetchStart;
    nodeIdT fetchNode;
    logic edgesDone;
    logic edgeValid;
    nodeIdT edgeTarget;
    weightT edgeWeight;
    logic edgeAck;
    logic clearStart;
    logic clearDone;
    logic seedStart;
    nodeIdT seedNode;
    logic seedDone;
    nodeIdT nodeCount;
    distT distU;
    nodeIdT nodeU;
    logic updated;
    logic walkStart;
    nodeIdT walkNode;
    logic pathValid;
    nodeIdT pathNode;
    distT pathDist;
    logic pathEnd;
    logic writeDone;

    bfController bfController_i (
        .clock(clock),
        .reset(reset),
        .inAddr(inAddr),
        .inData(inData),
        .workAddrA(workAddrA),
        .workDataA(workDataA),
        .fetchStart(fetchStart),
        .fetchNode(fetchNode),
        .edgesDone(edgesDone),
        .clearStart(clearStart),
        .seedStart(seedStart),
        .seedNode(seedNode),
        .clearDone(clearDone),
        .seedDone(seedDone),
        .updated(updated),
        .nodeCount(nodeCount),
        .distU(distU),
        .nodeU(nodeU),
        .walkStart(walkStart),
        .walkNode(walkNode),
        .writeDone(writeDone),
        .negCycle(negCycle),
        .done(done)
    );

    bfEdgeFetch bfEdgeFetch_i (
        .clock(clock),
        .reset(reset),
        .graphAddr(graphAddr),
        .graphData(graphData),
        .fetchStart(fetchStart),
        .fetchNode(fetchNode),
        .edgeValid(edgeValid),
        .edgeTarget(edgeTarget),
        .edgeWeight(edgeWeight),
        .edgeAck(edgeAck),
        .edgesDone(edgesDone)
    );

    bfDistanceStore bfDistanceStore_i (
        .clock(clock),
        .reset(reset),
        .workAddrB(workAddrB),
        .workDataB(workDataB),
        .workWrAddr(workWrAddr),
        .workWrData(workWrData),
        .workWe(workWe),
        .clearStart(clearStart),
        .seedStart(seedStart),
        .seedNode(seedNode),
        .clearDone(clearDone),
        .seedDone(seedDone),
        .nodeCount(nodeCount),
        .edgeValid(edgeValid),
        .edgeTarget(edgeTarget),
        .edgeWeight(edgeWeight),
        .distU(distU),
        .nodeU(nodeU),
        .edgeAck(edgeAck),
        .updated(updated),
        .walkStart(walkStart),
        .walkNode(walkNode),
        .pathValid(pathValid),
        .pathNode(pathNode),
        .pathDist(pathDist),
        .pathEnd(pathEnd)
    );

    bfPathWriter #(
        .OutBase(OutBase)
    ) bfPathWriter_i (
        .clock(clock),
        .reset(reset),
        .pathValid(pathValid),
        .pathNode(pathNode),
        .pathDist(pathDist),
        .pathEnd(pathEnd),
        .outWrAddr(outWrAddr),
        .outWrData(outWrData),
        .outWe(outWe),
        .writeDone(writeDone)
    );

endmodule

//--- bfTbMemories.sv
module bfTbMemories
    import bfPkg::*;
#(
    parameter memAddrT OutBase = 13'h0000
)
(
    input  logic    clock,
    input  memAddrT inAddr,
    output nodeIdT  inData,
    input  memAddrT graphAddr,
    output lineT    graphData,
    input  memAddrT workAddrA,
    input  memAddrT workAddrB,
    output lineT    workDataA,
    output lineT    workDataB,
    input  memAddrT workWrAddr,
    input  lineT    workWrData,
    input  logic    workWe,
    input  memAddrT outWrAddr,
    input  outWordT outWrData,
    input  logic    outWe
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int LineBase = 32;   // Adjacency lines start above the index words

    nodeIdT inMem [0:3];
    lineT graphMem [0:255];
    lineT workMem [0:255];
    nodeIdT adjTarget [1:15][0:15];
    weightT adjWeight [1:15][0:15];
    int adjCount [1:15];
    outWordT outWords [0:31];
    int outCount;

    // Registered reads, one cycle from address to data
    always @(posedge clock)
    begin
        inData <= inMem[inAddr[1:0]];
        graphData <= graphMem[graphAddr[7:0]];
        if (workWe)
            workMem[workWrAddr[7:0]] <= workWrData;
        workDataA <= (workWe && workWrAddr == workAddrA) ? workWrData : workMem[workAddrA[7:0]];
        workDataB <= (workWe && workWrAddr == workAddrB) ? workWrData : workMem[workAddrB[7:0]];
        if (outWe)
        begin
            if (outWrAddr - OutBase < 13'd32)
                outWords[5'(outWrAddr - OutBase)] <= outWrData;
            outCount <= outCount + 1;
        end
    end

    task automatic clearImage();
        for (int a = 0; a < 256; a++)
        begin
            graphMem[a] = '0;
            workMem[a] = '0;
        end
        for (int u = 1; u < 16; u++)
            adjCount[u] = 0;
        for (int i = 0; i < 32; i++)
            outWords[i] = 'x;  // Unwritten slots never match an expected word
        for (int i = 0; i < 4; i++)
            inMem[i] = '0;
        outCount = 0;
    endtask

    task automatic setQuery(input nodeIdT nodes, input nodeIdT source, input nodeIdT dest);
        inMem[0] = nodes;
        inMem[1] = source;
        inMem[2] = dest;
    endtask

    task automatic addEdge(input nodeIdT srcNode, input nodeIdT dstNode, input weightT weight);
        adjTarget[srcNode][adjCount[srcNode]] = dstNode;
        adjWeight[srcNode][adjCount[srcNode]] = weight;
        adjCount[srcNode]++;
    endtask

    task automatic buildGraph(input int nodes);
        int lineAddr;
        int line;
        int slot;
        int extra;
        lineAddr = LineBase;
        for (int u = 1; u <= nodes; u++)
        begin
            graphMem[u] = lineT'(lineAddr);
            graphMem[lineAddr][LinkCountMsb:LinkCountLsb] = 8'(adjCount[u]);
            for (int k = 0; k < adjCount[u]; k++)
            begin
                if (k < int'(FirstLinePairs))
                begin
                    line = lineAddr;
                    slot = 111 - 16 * k;    // Top pair slot holds the link count
                end
                else
                begin
                    line = lineAddr + 1 + (k - int'(FirstLinePairs)) / int'(LinePairs);
                    slot = 127 - 16 * ((k - int'(FirstLinePairs)) % int'(LinePairs));
                end
                graphMem[line][slot -: 8] = adjTarget[u][k];
                graphMem[line][slot - 8 -: 8] = adjWeight[u][k];
            end
            extra = 0;
            if (adjCount[u] > int'(FirstLinePairs))
                extra = (adjCount[u] - int'(FirstLinePairs) + int'(LinePairs) - 1) / int'(LinePairs);
            lineAddr += 1 + extra;
        end
    endtask

endmodule

//--- bellmanFordTb.sv
module bellmanFordTb;
    import bfPkg::*;
    timeunit 1ns;
    timeprecision 100ps;

    localparam memAddrT OutBase = 13'h0200;

    logic clock;
    logic reset;
    memAddrT inAddr;
    nodeIdT inData;
    memAddrT graphAddr;
    lineT graphData;
    memAddrT workAddrA;
    memAddrT workAddrB;
    lineT workDataA;
    lineT workDataB;
    memAddrT workWrAddr;
    lineT workWrData;
    logic workWe;
    memAddrT outWrAddr;
    outWordT outWrData;
    logic outWe;
    logic negCycle;
    logic done;

    // Test table, edges and expected words are flat lists indexed per row
    int rowTotal = 0;
    int rowNodes [0:7];
    int rowSource [0:7];
    int rowDest [0:7];
    logic rowNeg [0:7];
    int rowRestart [0:7];   // Cycles into a first attempt before reset, 0 for none
    logic rowFanOut [0:7];  // Node 1 fans out to nodes 2 to 11
    int rowEdgeFirst [0:7];
    int rowEdgeCount [0:7];
    int rowWordFirst [0:7];
    int rowWordCount [0:7];
    int edgeTotal = 0;
    nodeIdT edgeFrom [0:63];
    nodeIdT edgeTo [0:63];
    weightT edgeWeight [0:63];
    int wordTotal = 0;
    outWordT expWords [0:63];

    int cycleCount = 0;
    int cycleLimit = 0;

    bellmanFordTop #(
        .OutBase(OutBase)
    ) bellmanFordTop_i (
        .clock(clock),
        .reset(reset),
        .inAddr(inAddr),
        .inData(inData),
        .graphAddr(graphAddr),
        .graphData(graphData),
        .workAddrA(workAddrA),
        .workAddrB(workAddrB),
        .workDataA(workDataA),
        .workDataB(workDataB),
        .workWrAddr(workWrAddr),
        .workWrData(workWrData),
        .workWe(workWe),
        .outWrAddr(outWrAddr),
        .outWrData(outWrData),
        .outWe(outWe),
        .negCycle(negCycle),
        .done(done)
    );

    bfTbMemories #(
        .OutBase(OutBase)
    ) bfTbMemories_i (
        .clock(clock),
        .inAddr(inAddr),
        .inData(inData),
        .graphAddr(graphAddr),
        .graphData(graphData),
        .workAddrA(workAddrA),
        .workAddrB(workAddrB),
        .workDataA(workDataA),
        .workDataB(workDataB),
        .workWrAddr(workWrAddr),
        .workWrData(workWrData),
        .workWe(workWe),
        .outWrAddr(outWrAddr),
        .outWrData(outWrData),
        .outWe(outWe)
    );

    initial
    begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    task automatic stopRun();
        $display("Test failed");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    always @(posedge clock)
    begin
        cycleCount <= cycleCount + 1;
        if (cycleLimit > 0 && cycleCount > cycleLimit)
        begin
            $display("Timeout: no done from the DUT within %0d cycles", cycleLimit);
            stopRun();
        end
    end

    task automatic newRow(input int nodes, input int source, input int dest,
                          input logic negExp, input int restart);
        rowNodes[rowTotal] = nodes;
        rowSource[rowTotal] = source;
        rowDest[rowTotal] = dest;
        rowNeg[rowTotal] = negExp;
        rowRestart[rowTotal] = restart;
        rowFanOut[rowTotal] = 1'b0;
        rowEdgeFirst[rowTotal] = edgeTotal;
        rowEdgeCount[rowTotal] = 0;
        rowWordFirst[rowTotal] = wordTotal;
        rowWordCount[rowTotal] = 0;
        rowTotal++;
    endtask

    task automatic appendEdge(input nodeIdT u, input nodeIdT v, input weightT w);
        edgeFrom[edgeTotal] = u;
        edgeTo[edgeTotal] = v;
        edgeWeight[edgeTotal] = w;
        edgeTotal++;
        rowEdgeCount[rowTotal - 1]++;
    endtask

    task automatic expectWord(input outWordT w);
        expWords[wordTotal] = w;
        wordTotal++;
        rowWordCount[rowTotal - 1]++;
    endtask

    // Node 1 links to nodes 2 to 11, weight 10 plus the link number
    task automatic addFanOut();
        rowFanOut[rowTotal - 1] = 1'b1;
        for (int k = 1; k <= 10; k++)
            appendEdge(nodeIdT'(1), nodeIdT'(k + 1), weightT'(10 + k));
        expectWord(16'h0013);   // Ninth link, 1 -> 10 with weight 19
        expectWord(16'h000A);
        expectWord(16'h0001);
        expectWord(PathEnd);
    endtask

    task automatic buildTable();
        newRow(3, 1, 3, 1'b0, 0);   // Chain 1 -> 2 -> 3
        appendEdge(1, 2, 3);
        appendEdge(2, 3, 4);
        expectWord(16'h0007);
        expectWord(16'h0003);
        expectWord(16'h0002);
        expectWord(16'h0001);
        expectWord(PathEnd);
        // Direct edge loses to a two-hop route through a negative weight
        newRow(3, 1, 3, 1'b0, 0);
        appendEdge(1, 3, 3);
        appendEdge(1, 2, -5);
        appendEdge(2, 3, 1);
        expectWord(16'hFFFC);
        expectWord(16'h0003);
        expectWord(16'h0002);
        expectWord(16'h0001);
        expectWord(PathEnd);
        newRow(11, 1, 10, 1'b0, 0);
        addFanOut();
        newRow(4, 1, 4, 1'b0, 0);   // Destination cut off from the source
        appendEdge(1, 2, 1);
        appendEdge(3, 4, 2);
        expectWord(PathEnd);
        // Cycle 2 -> 3 -> 2 sums to -2
        newRow(3, 1, 3, 1'b1, 0);
        appendEdge(1, 2, 1);
        appendEdge(2, 3, -3);
        appendEdge(3, 2, 1);
        newRow(11, 1, 10, 1'b0, 60);    // Same fan-out, reset partway through
        addFanOut();
    endtask

    function automatic int timeBudget();
        int total;
        total = 0;
        for (int r = 0; r < rowTotal; r++)
        begin
            total += (rowNodes[r] + 1) * (rowNodes[r] + rowEdgeCount[r]) * 12 + 100;
            if (rowRestart[r] > 0)
                total += rowRestart[r] + 10;
        end
        return total;
    endfunction

    task automatic checkWord(input string name, input outWordT actual, input outWordT expected);
        if (actual !== expected)
        begin
            $display("FAIL t=%0t %s: got %h, expected %h", $time, name, actual, expected);
            stopRun();
        end
    endtask

    task automatic checkFlag(input string name, input logic actual, input logic expected);
        if (actual !== expected)
        begin
            $display("FAIL t=%0t %s: got %b, expected %b", $time, name, actual, expected);
            stopRun();
        end
    endtask

    task automatic checkCount(input string name, input int actual, input int expected);
        if (actual != expected)
        begin
            $display("FAIL t=%0t %s: got %0d, expected %0d", $time, name, actual, expected);
            stopRun();
        end
    endtask

    task automatic checkDist(input string name, input distT actual, input distT expected);
        if (actual !== expected)
        begin
            $display("FAIL t=%0t %s: got %0d, expected %0d", $time, name, actual, expected);
            stopRun();
        end
    endtask

    // Memories are loaded while reset is high
    task automatic startRow(input int r);
        reset = 1'b1;
        @(posedge clock);
        #1;
        bfTbMemories_i.clearImage();
        bfTbMemories_i.setQuery(rowNodes[r], rowSource[r], rowDest[r]);
        for (int e = rowEdgeFirst[r]; e < rowEdgeFirst[r] + rowEdgeCount[r]; e++)
            bfTbMemories_i.addEdge(edgeFrom[e], edgeTo[e], edgeWeight[e]);
        bfTbMemories_i.buildGraph(rowNodes[r]);
        repeat (3) @(posedge clock);
        #1;
        reset = 1'b0;
    endtask

    task automatic waitDone();
        while (done !== 1'b1)
        begin
            @(posedge clock);
            #1;
        end
    endtask

    task automatic checkRow(input int r);
        checkFlag("negCycle", negCycle, rowNeg[r]);    // Must rise in the same cycle as done
        repeat (3) @(posedge clock);    // A few idle cycles to catch stray writes
        #1;
        checkCount("outWe writes", bfTbMemories_i.outCount, rowWordCount[r]);
        for (int i = 0; i < rowWordCount[r]; i++)
            checkWord($sformatf("outWrData[%0d]", i), bfTbMemories_i.outWords[i],
                      expWords[rowWordFirst[r] + i]);
        // Every fan-out target is one hop from the source
        if (rowFanOut[r])
            for (int k = 1; k <= 10; k++)
                checkDist($sformatf("distance of node %0d", k + 1),
                          distT'(bfTbMemories_i.workMem[k + 1][DistMsb:DistLsb]),
                          distT'(10 + k));
    endtask

    initial
    begin
        reset = 1'b1;
        buildTable();
        cycleLimit = timeBudget();
        for (int r = 0; r < rowTotal; r++)
        begin
            if (rowRestart[r] > 0)
            begin
                startRow(r);
                repeat (rowRestart[r]) @(posedge clock);
                #1;
                if (done)
                begin
                    $display("Row %0d finished before the reset at cycle %0d", r, rowRestart[r]);
                    stopRun();
                end
            end
            startRow(r);
            waitDone();
            checkRow(r);
        end
        $display("Test passed");
        $finish;
    end

endmodule

//--- sources.f
bfPkg.sv
bfController.sv
bfEdgeFetch.sv
bfDistanceStore.sv
bfPathWriter.sv
bellmanFordTop.sv
bfTbMemories.sv
bellmanFordTb.sv

//--- Bender.yml
package:
  name: bellman_ford

sources:
  - bfPkg.sv
  - bfController.sv
  - bfEdgeFetch.sv
  - bfDistanceStore.sv
  - bfPathWriter.sv
  - bellmanFordTop.sv
  - target: test
    files:
      - bfTbMemories.sv
      - bellmanFordTb.sv
